//--- src.f
hw/csa_pkg.sv
hw/stream_iteration.sv
hw/stream_byte.sv
hw/csa_cmd_decode.sv
hw/csa_stream_exec.sv
hw/csa_result.sv
hw/csa_stream_top.sv
bench/tb_clock.sv
bench/csa_tb.sv

//--- Bender.yml
package:
  name: csa_stream

sources:
  - hw/csa_pkg.sv
  - hw/stream_iteration.sv
  - hw/stream_byte.sv
  - hw/csa_cmd_decode.sv
  - hw/csa_stream_exec.sv
  - hw/csa_result.sv
  - hw/csa_stream_top.sv
  - target: test
    files:
      - bench/tb_clock.sv
      - bench/csa_tb.sv

//--- bench/csa_tb.sv
`timescale 1ns/100ps

module csa_tb;

  import csa_pkg::*;

  localparam int cmd_count       = 180;                  // upper bound over all phases
  localparam int watchdog_cycles = 2 * cmd_count + 40;   // room for a gap per command

  logic        clk;
  logic        arst_n;
  csa_cmd_t    cmd;
  csa_result_t res;

  logic [31:0] lfsr_q = 32'h5662;
  logic        exp_valid = 1'b0;
  logic [7:0]  exp_data = 8'h00;
  int          gen_count = 0;
  int          res_count = 0;
  logic [7:0]  res_q [$];

  // reference cipher state, nibble 1 is the newest
  logic [3:0]  ma [1:10];
  logic [3:0]  mb [1:10];
  logic [3:0]  md, me, mf, mx, my, mz;
  logic        mp, mq, mr;
  csa_key_t    mkey = '0;

  tb_clock u_clock (.clk(clk), .arst_n(arst_n));

  csa_stream_top UUT (.clk(clk), .arst_n(arst_n), .cmd(cmd), .res(res));

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Test failed");
    $fatal(1);
  endtask

  function automatic logic next_rand_bit();
    logic lsb;
    lsb    = lfsr_q[0];
    lfsr_q = lfsr_q >> 1;
    if (lsb) begin
      lfsr_q = lfsr_q ^ 32'hA300_0000;
    end
    return lsb;
  endfunction

  function automatic logic [7:0] rand_byte();
    logic [7:0] v;
    for (int i = 0; i < 8; i++) begin
      v = {v[6:0], next_rand_bit()};
    end
    return v;
  endfunction

  task automatic load_model_state();
    for (int k = 1; k <= 10; k++) begin
      ma[k] = (k <= 8) ? mkey[67-4*k -: 4] : 4'h0;  // nibble 1 is key[63:60]
      mb[k] = (k <= 8) ? mkey[35-4*k -: 4] : 4'h0;
    end
    {md, me, mf, mx, my, mz} = '0;
    {mp, mq, mr} = '0;
  endtask

  task automatic clock_model_iteration(input logic [3:0] in1, input logic [3:0] in2,
                                       input logic init, output logic [1:0] bits);
    logic [1:0] s [1:7];
    logic [3:0] extra;
    logic [3:0] na1;
    logic [3:0] nb1;
    logic [3:0] dn;
    logic [3:0] old_e;
    logic [4:0] sum;
    s[1] = sbox1({ma[4][0], ma[1][2], ma[6][1], ma[7][3], ma[9][0]});
    s[2] = sbox2({ma[2][1], ma[3][2], ma[6][3], ma[7][0], ma[9][1]});
    s[3] = sbox3({ma[1][3], ma[2][0], ma[5][1], ma[5][3], ma[6][2]});
    s[4] = sbox4({ma[3][3], ma[1][1], ma[2][3], ma[4][2], ma[8][0]});
    s[5] = sbox5({ma[5][2], ma[4][3], ma[6][0], ma[8][1], ma[9][2]});
    s[6] = sbox6({ma[3][1], ma[4][1], ma[5][0], ma[7][2], ma[9][3]});
    s[7] = sbox7({ma[2][2], ma[3][0], ma[7][1], ma[8][2], ma[8][3]});
    extra[3] = mb[3][0] ^ mb[6][1] ^ mb[7][2] ^ mb[9][3];
    extra[2] = mb[6][0] ^ mb[8][1] ^ mb[3][3] ^ mb[4][2];
    extra[1] = mb[5][3] ^ mb[8][2] ^ mb[4][0] ^ mb[5][1];
    extra[0] = mb[9][2] ^ mb[6][3] ^ mb[3][1] ^ mb[8][0];
    na1 = init ? (ma[10] ^ mx ^ md ^ in2) : (ma[10] ^ mx);
    nb1 = init ? (mb[7] ^ mb[10] ^ my ^ in1) : (mb[7] ^ mb[10] ^ my);
    if (mp) begin
      nb1 = {nb1[2:0], nb1[3]};
    end
    dn  = me ^ mz ^ extra;
    sum = mz + me + mr;  // 5 bit add keeps the carry
    for (int k = 10; k >= 2; k--) begin
      ma[k] = ma[k-1];
      mb[k] = mb[k-1];
    end
    ma[1] = na1;
    mb[1] = nb1;
    old_e = me;
    me    = mf;
    if (mq) begin
      mf = sum[3:0];
      mr = sum[4];
    end else begin
      mf = old_e;
    end
    md = dn;
    mx = {s[4][0], s[3][0], s[2][1], s[1][1]};
    my = {s[6][0], s[5][0], s[4][1], s[3][1]};
    mz = {s[2][0], s[1][0], s[6][1], s[5][1]};
    mp = s[7][1];
    mq = s[7][0];
    bits = {dn[3] ^ dn[2], dn[1] ^ dn[0]};
  endtask

  task automatic step_model_byte(input logic [7:0] sb, input logic init,
                                 output logic [7:0] ks);
    logic [1:0] bits;
    for (int i = 0; i < 4; i++) begin
      if (i % 2 == 0) begin
        clock_model_iteration(sb[3:0], sb[7:4], init, bits);
      end else begin
        clock_model_iteration(sb[7:4], sb[3:0], init, bits);
      end
      ks[7-2*i -: 2] = bits;  // msb pair first
    end
  endtask

  task automatic check_result();
    string msg;
    if (res.valid === 1'b1) begin
      res_count++;
      res_q.push_back(res.data);
    end
    assert (res.valid === exp_valid) else begin
      msg = $sformatf("ERROR res.valid got 0x%0h expected 0x%0h", res.valid, exp_valid);
      abort_run(msg);
    end
    if (exp_valid) begin
      assert (res.data === exp_data) else begin
        msg = $sformatf("ERROR res.data got 0x%02h expected 0x%02h", res.data, exp_data);
        abort_run(msg);
      end
    end
  endtask

  task automatic idle_cycle();
    @(negedge clk);
    check_result();
    cmd.valid = 1'b0;
    exp_valid = 1'b0;
  endtask

  task automatic issue_cmd(input csa_op_e op, input logic [7:0] data);
    logic [7:0] ks;
    @(negedge clk);
    check_result();  // result of the previous cycle
    cmd.valid = 1'b1;
    cmd.op    = op;
    cmd.data  = data;
    exp_valid = 1'b0;
    case (op)
      op_key:   mkey = {mkey[55:0], data};
      op_start: load_model_state();
      op_init:  step_model_byte(data, 1'b1, ks);
      default: begin
        step_model_byte(data, 1'b0, ks);
        exp_valid = 1'b1;
        exp_data  = data ^ ks;
        gen_count++;
      end
    endcase
  endtask

  task automatic maybe_gap();
    logic g0;
    logic g1;
    g0 = next_rand_bit();
    g1 = next_rand_bit();
    if (g0 & g1) begin
      idle_cycle();
    end
  endtask

  task automatic load_key(input csa_key_t k);
    for (int i = 0; i < 8; i++) begin
      issue_cmd(op_key, k[63-8*i -: 8]);
      maybe_gap();
    end
  endtask

  task automatic capture_zero_stream(output logic [63:0] stream);
    for (int i = 0; i < 8; i++) begin
      issue_cmd(op_gen, 8'h00);  // result is the raw keystream
    end
    idle_cycle();
    for (int i = 0; i < 8; i++) begin
      stream = {stream[55:0], res_q[res_q.size()-8+i]};
    end
  endtask

  initial begin
    #(watchdog_cycles * 8);
    abort_run("watchdog expired before the command sequence finished");
  end

  initial begin
    csa_key_t   key_b;
    logic [7:0] init_a [8];
    logic [63:0] stream_a;
    logic [63:0] stream_b;
    cmd = '0;
    @(posedge arst_n);
    repeat (3) idle_cycle();
    // first key, init, long generate run
    load_key({rand_byte(), rand_byte(), rand_byte(), rand_byte(),
              rand_byte(), rand_byte(), rand_byte(), rand_byte()});
    issue_cmd(op_start, rand_byte());
    for (int i = 0; i < 8; i++) begin
      issue_cmd(op_init, rand_byte());
      maybe_gap();
    end
    for (int i = 0; i < 64; i++) begin
      issue_cmd(op_gen, rand_byte());
      maybe_gap();
    end
    // key bytes interleaved with generates, then restart
    for (int i = 0; i < 8; i++) begin
      key_b[63-8*i -: 8] = rand_byte();
      issue_cmd(op_key, key_b[63-8*i -: 8]);
      issue_cmd(op_gen, rand_byte());
    end
    issue_cmd(op_start, 8'h00);
    for (int i = 0; i < 8; i++) begin
      issue_cmd(op_init, rand_byte());
    end
    for (int i = 0; i < 32; i++) begin
      issue_cmd(op_gen, rand_byte());
      maybe_gap();
    end
    // same key, two init vectors
    issue_cmd(op_start, 8'h00);
    for (int i = 0; i < 8; i++) begin
      init_a[i] = rand_byte();
      issue_cmd(op_init, init_a[i]);
    end
    capture_zero_stream(stream_a);
    issue_cmd(op_start, 8'h00);
    for (int i = 0; i < 8; i++) begin
      issue_cmd(op_init, init_a[i] ^ 8'h5a);
    end
    capture_zero_stream(stream_b);
    assert (stream_a !== stream_b) else begin
      abort_run("two different init vectors produced the same keystream");
    end
    repeat (2) idle_cycle();
    assert (res_count == gen_count) else begin
      abort_run($sformatf("ERROR result count got 0x%0h expected 0x%0h",
                          res_count, gen_count));
    end
    $display("Test completed successfully");
    $finish;
  end

endmodule

//--- bench/tb_clock.sv
`timescale 1ns/100ps

module tb_clock (
  output logic clk,
  output logic arst_n
);

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;  // 8 ns period
  end

  initial begin
    arst_n = 1'b0;
    repeat (5) @(posedge clk);
    @(negedge clk);
    arst_n = 1'b1;  // release away from the active edge
  end

endmodule

//--- hw/csa_stream_top.sv
`timescale 1ns/100ps

module csa_stream_top (
  input  logic                 clk,
  input  logic                 arst_n,
  input  csa_pkg::csa_cmd_t    cmd,
  output csa_pkg::csa_result_t res
);

  import csa_pkg::*;

  logic       ctl_load;
  logic       ctl_step;
  logic       ctl_init;
  logic [7:0] sb;
  csa_key_t   key;
  logic       gen_strobe;
  logic [7:0] gen_data;
  logic [7:0] ks_byte;

  csa_cmd_decode u_decode (
    .clk        (clk),
    .arst_n     (arst_n),
    .cmd        (cmd),
    .ctl_load   (ctl_load),
    .ctl_step   (ctl_step),
    .ctl_init   (ctl_init),
    .sb         (sb),
    .key        (key),
    .gen_strobe (gen_strobe),
    .gen_data   (gen_data)
  );

  csa_stream_exec u_exec (
    .clk      (clk),
    .arst_n   (arst_n),
    .ctl_load (ctl_load),
    .ctl_step (ctl_step),
    .ctl_init (ctl_init),
    .sb       (sb),
    .key      (key),
    .ks_byte  (ks_byte)
  );

  csa_result u_result (
    .clk        (clk),
    .arst_n     (arst_n),
    .gen_strobe (gen_strobe),
    .gen_data   (gen_data),
    .ks_byte    (ks_byte),
    .res        (res)
  );

endmodule

//--- hw/csa_result.sv
`timescale 1ns/100ps

module csa_result (
  input  logic                 clk,
  input  logic                 arst_n,
  input  logic                 gen_strobe,
  input  logic [7:0]           gen_data,
  input  logic [7:0]           ks_byte,
  output csa_pkg::csa_result_t res
);

  logic       valid_q;
  logic [7:0] data_q;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= gen_strobe;  // one pulse per op_gen
    end
  end

  always_ff @(posedge clk) begin
    if (gen_strobe) begin
      data_q <= gen_data ^ ks_byte;
    end
  end

  assign res.valid = valid_q;
  assign res.data  = data_q;

endmodule

//--- hw/csa_stream_exec.sv
`timescale 1ns/100ps

module csa_stream_exec (
  input  logic              clk,
  input  logic              arst_n,
  input  logic              ctl_load,
  input  logic              ctl_step,
  input  logic              ctl_init,
  input  logic [7:0]        sb,
  input  csa_pkg::csa_key_t key,
  output logic [7:0]        ks_byte
);

  import csa_pkg::*;

  csa_state_t state_q;
  csa_state_t state_step;
  csa_state_t state_load;

  // key schedule: a nibbles 1..8 from key[63:32], b from key[31:0]
  always_comb begin
    state_load = '0;
    for (int i = 0; i < 8; i++) begin
      state_load.a[4*i +: 4] = key[60-4*i +: 4];
      state_load.b[4*i +: 4] = key[28-4*i +: 4];
    end
  end

  stream_byte u_byte (
    .init   (ctl_init),
    .sb     (sb),
    .st_in  (state_q),
    .st_out (state_step),
    .op     (ks_byte)  // from the current state
  );

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state_q <= '0;
    end else if (ctl_load) begin
      state_q <= state_load;
    end else if (ctl_step) begin
      state_q <= state_step;
    end
  end

endmodule

//--- hw/csa_cmd_decode.sv
`timescale 1ns/100ps

module csa_cmd_decode (
  input  logic              clk,
  input  logic              arst_n,
  input  csa_pkg::csa_cmd_t cmd,
  output logic              ctl_load,
  output logic              ctl_step,
  output logic              ctl_init,
  output logic [7:0]        sb,
  output csa_pkg::csa_key_t key,
  output logic              gen_strobe,
  output logic [7:0]        gen_data
);

  import csa_pkg::*;

  logic     is_key;
  logic     is_start;
  logic     is_init;
  logic     is_gen;
  csa_key_t key_q;

  always_comb begin
    is_key   = 1'b0;
    is_start = 1'b0;
    is_init  = 1'b0;
    is_gen   = 1'b0;
    if (cmd.valid) begin
      case (cmd.op)
        op_key:   is_key   = 1'b1;
        op_start: is_start = 1'b1;
        op_init:  is_init  = 1'b1;
        op_gen:   is_gen   = 1'b1;
        default:  is_key   = 1'b0;
      endcase
    end
  end

  // bytes enter at the lsb end
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      key_q <= '0;
    end else if (is_key) begin
      key_q <= {key_q[55:0], cmd.data};
    end
  end

  assign ctl_load   = is_start;
  assign ctl_step   = is_init | is_gen;
  assign ctl_init   = is_init;
  assign sb         = cmd.data;
  assign key        = key_q;
  assign gen_strobe = is_gen;
  assign gen_data   = cmd.data;

endmodule

//--- hw/stream_byte.sv
`timescale 1ns/100ps

module stream_byte (
  input  logic                init,
  input  logic [7:0]          sb,
  input  csa_pkg::csa_state_t st_in,
  output csa_pkg::csa_state_t st_out,
  output logic [7:0]          op
);

  import csa_pkg::*;

  csa_state_t st_chain [0:4];
  logic [7:0] op_raw;

  assign st_chain[0] = st_in;

  for (genvar i = 0; i < 4; i++) begin : g_iter
    logic [3:0] nib_1;
    logic [3:0] nib_2;

    // even steps take low/high, odd steps high/low
    assign nib_1 = (i % 2 == 0) ? sb[3:0] : sb[7:4];
    assign nib_2 = (i % 2 == 0) ? sb[7:4] : sb[3:0];

    stream_iteration u_iter (
      .in1    (nib_1),
      .in2    (nib_2),
      .init   (init),
      .st_in  (st_chain[i]),
      .st_out (st_chain[i+1]),
      .op     (op_raw[7-2*i -: 2])  // first pair lands in the msbs
    );
  end

  assign st_out = st_chain[4];
  assign op     = init ? sb : op_raw;  // init echoes the input byte

endmodule

//--- hw/stream_iteration.sv
`timescale 1ns/100ps

module stream_iteration (
  input  logic [3:0]          in1,
  input  logic [3:0]          in2,
  input  logic                init,
  input  csa_pkg::csa_state_t st_in,
  output csa_pkg::csa_state_t st_out,
  output logic [1:0]          op
);

  import csa_pkg::*;

  logic [3:0] an [1:10];  // nibble views of a
  logic [3:0] bn [1:10];  // nibble views of b

  logic [1:0] s1;
  logic [1:0] s2;
  logic [1:0] s3;
  logic [1:0] s4;
  logic [1:0] s5;
  logic [1:0] s6;
  logic [1:0] s7;

  logic [3:0] extra_b;
  logic [3:0] next_a1;
  logic [3:0] b_mix;
  logic [3:0] next_b1;
  logic [3:0] d_new;
  logic [4:0] sum;

  always_comb begin
    for (int k = 1; k <= 10; k++) begin
      an[k] = st_in.a[4*k-4 +: 4];
      bn[k] = st_in.b[4*k-4 +: 4];
    end
  end

  // 35 bits of a feed the seven boxes
  assign s1 = sbox1({an[4][0], an[1][2], an[6][1], an[7][3], an[9][0]});
  assign s2 = sbox2({an[2][1], an[3][2], an[6][3], an[7][0], an[9][1]});
  assign s3 = sbox3({an[1][3], an[2][0], an[5][1], an[5][3], an[6][2]});
  assign s4 = sbox4({an[3][3], an[1][1], an[2][3], an[4][2], an[8][0]});
  assign s5 = sbox5({an[5][2], an[4][3], an[6][0], an[8][1], an[9][2]});
  assign s6 = sbox6({an[3][1], an[4][1], an[5][0], an[7][2], an[9][3]});
  assign s7 = sbox7({an[2][2], an[3][0], an[7][1], an[8][2], an[8][3]});

  // 4x4 xor network over b
  assign extra_b[3] = bn[3][0] ^ bn[6][1] ^ bn[7][2] ^ bn[9][3];
  assign extra_b[2] = bn[6][0] ^ bn[8][1] ^ bn[3][3] ^ bn[4][2];
  assign extra_b[1] = bn[5][3] ^ bn[8][2] ^ bn[4][0] ^ bn[5][1];
  assign extra_b[0] = bn[9][2] ^ bn[6][3] ^ bn[3][1] ^ bn[8][0];

  // feedback into a and b, input nibbles only in init mode
  assign next_a1 = init ? an[10] ^ st_in.x ^ st_in.d ^ in2
                        : an[10] ^ st_in.x;
  assign b_mix   = init ? bn[7] ^ bn[10] ^ st_in.y ^ in1
                        : bn[7] ^ bn[10] ^ st_in.y;
  assign next_b1 = st_in.p ? {b_mix[2:0], b_mix[3]} : b_mix;  // rotate left when p

  assign d_new = st_in.e ^ st_in.z ^ extra_b;
  assign sum   = {1'b0, st_in.z} + {1'b0, st_in.e} + {4'b0, st_in.r};

  always_comb begin
    st_out   = st_in;
    st_out.a = {st_in.a[35:0], next_a1};
    st_out.b = {st_in.b[35:0], next_b1};
    st_out.d = d_new;
    st_out.e = st_in.f;
    if (st_in.q) begin
      st_out.f = sum[3:0];
      st_out.r = sum[4];  // carry
    end else begin
      st_out.f = st_in.e;
      st_out.r = st_in.r;
    end
    st_out.x = {s4[0], s3[0], s2[1], s1[1]};
    st_out.y = {s6[0], s5[0], s4[1], s3[1]};
    st_out.z = {s2[0], s1[0], s6[1], s5[1]};
    st_out.p = s7[1];
    st_out.q = s7[0];
  end

  // two output bits, pairwise xor of the new d
  assign op = {d_new[3] ^ d_new[2], d_new[1] ^ d_new[0]};

endmodule

//--- hw/csa_pkg.sv
package csa_pkg;

  typedef enum logic [1:0] {
    op_key   = 2'd0,  // shift in one key byte
    op_start = 2'd1,  // load state from key
    op_init  = 2'd2,  // absorb one init byte
    op_gen   = 2'd3   // produce one keystream byte
  } csa_op_e;

  typedef logic [63:0] csa_key_t;

  typedef struct packed {
    logic       valid;
    csa_op_e    op;
    logic [7:0] data;
  } csa_cmd_t;

  // nibble k of a and b sits at bits [4k-1:4k-4], k = 1..10
  typedef struct packed {
    logic [39:0] a;
    logic [39:0] b;
    logic [3:0]  d;
    logic [3:0]  e;
    logic [3:0]  f;
    logic [3:0]  x;
    logic [3:0]  y;
    logic [3:0]  z;
    logic        p;
    logic        q;
    logic        r;
  } csa_state_t;

  typedef struct packed {
    logic       valid;
    logic [7:0] data;
  } csa_result_t;

  localparam logic [1:0] sbox1_tbl [32] = '{2, 0, 1, 1, 2, 3, 3, 0, 3, 2, 2, 0, 1, 1, 0, 3,
                                            0, 3, 3, 0, 2, 2, 1, 1, 2, 2, 0, 3, 1, 1, 3, 0};
  localparam logic [1:0] sbox2_tbl [32] = '{3, 1, 0, 2, 2, 3, 3, 0, 1, 3, 2, 1, 0, 0, 1, 2,
                                            3, 1, 0, 3, 3, 2, 0, 2, 0, 0, 1, 2, 2, 1, 3, 1};
  localparam logic [1:0] sbox3_tbl [32] = '{2, 0, 1, 2, 2, 3, 3, 1, 1, 1, 0, 3, 3, 0, 2, 0,
                                            1, 3, 0, 1, 3, 0, 2, 2, 2, 0, 1, 2, 0, 3, 3, 1};
  localparam logic [1:0] sbox4_tbl [32] = '{3, 1, 2, 3, 0, 2, 1, 2, 1, 2, 0, 1, 3, 0, 0, 3,
                                            1, 0, 3, 1, 2, 3, 0, 3, 0, 3, 2, 0, 1, 2, 2, 1};
  localparam logic [1:0] sbox5_tbl [32] = '{2, 0, 0, 1, 3, 2, 3, 2, 0, 1, 3, 3, 1, 0, 2, 1,
                                            2, 3, 2, 0, 0, 3, 1, 1, 1, 0, 3, 2, 3, 1, 0, 2};
  localparam logic [1:0] sbox6_tbl [32] = '{0, 1, 2, 3, 1, 2, 2, 0, 0, 1, 3, 0, 2, 3, 1, 3,
                                            2, 3, 0, 2, 3, 0, 1, 1, 2, 1, 1, 2, 0, 3, 3, 0};
  localparam logic [1:0] sbox7_tbl [32] = '{0, 3, 2, 2, 3, 0, 0, 1, 3, 0, 1, 3, 1, 2, 2, 1,
                                            1, 0, 3, 3, 0, 1, 1, 2, 2, 3, 1, 0, 2, 3, 0, 2};

  function automatic logic [1:0] sbox1(input logic [4:0] idx);
    return sbox1_tbl[idx];
  endfunction

  function automatic logic [1:0] sbox2(input logic [4:0] idx);
    return sbox2_tbl[idx];
  endfunction

  function automatic logic [1:0] sbox3(input logic [4:0] idx);
    return sbox3_tbl[idx];
  endfunction

  function automatic logic [1:0] sbox4(input logic [4:0] idx);
    return sbox4_tbl[idx];
  endfunction

  function automatic logic [1:0] sbox5(input logic [4:0] idx);
    return sbox5_tbl[idx];
  endfunction

  function automatic logic [1:0] sbox6(input logic [4:0] idx);
    return sbox6_tbl[idx];
  endfunction

  function automatic logic [1:0] sbox7(input logic [4:0] idx);
    return sbox7_tbl[idx];
  endfunction

endpackage
